// ==== test/mem_trace.txt ====
// columns: op (0 fetch, 1 load, 2 store) size (0 byte, 1 half, 2 word) unsigned
// address data expected_data expected_error, all in hex
2 2 0 0100 8192a3b4 00000000 0
1 2 0 0100 00000000 8192a3b4 0
1 0 0 0100 00000000 ffffffb4 0
1 0 1 0101 00000000 000000a3 0
1 0 0 0103 00000000 ffffff81 0
1 1 0 0102 00000000 ffff8192 0
1 1 1 0100 00000000 0000a3b4 0
2 0 0 0105 0000007f 00000000 0
2 1 0 0106 0000fe01 00000000 0
1 2 0 0104 00000000 fe017f00 0
1 0 0 0105 00000000 0000007f 0
1 1 0 0106 00000000 fffffe01 0
2 1 0 0109 00001234 00000000 1
2 2 0 010a deadbeef 00000000 1
1 2 0 0108 00000000 00000000 0
1 1 0 0103 00000000 00000000 1
1 2 0 0101 00000000 00000000 1
0 0 0 0100 00000000 8192a3b4 0
0 0 0 0104 00000000 fe017f00 0
0 0 0 0102 00000000 7f008192 0
2 2 0 0200 11223344 00000000 0
2 0 0 0200 000000aa 00000000 0
1 2 0 0200 00000000 112233aa 0
1 0 1 0201 00000000 00000033 0
1 0 0 0202 00000000 00000022 0
1 0 0 0203 00000000 00000011 0
1 1 1 0200 00000000 000033aa 0
1 1 0 0202 00000000 00001122 0
2 2 0 0204 89abcdef 00000000 0
0 0 0 0204 00000000 89abcdef 0
1 0 0 0204 00000000 ffffffef 0
0 0 0 0000 00000000 00000000 0
f 0 0 0000 00000000 00000000 0

// ==== mem_subsys.f ====
+incdir+common
common/mem_pkg.sv
design/mem_ctrl.sv
design/store_align.sv
design/ram_mem.sv
design/load_extend.sv
design/rsp_fifo.sv
design/mem_subsys.sv
test/mem_checker.sv
test/mem_subsys_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the memory subsystem testbench with Verilator and run it.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module mem_subsys_tb \
    -f mem_subsys.f -o mem_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Build failed, see build.log"
    exit 1
fi

./obj_dir/mem_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Test failed" sim.log; then
    exit 1
fi
exit 0

// ==== test/mem_subsys_tb.sv ====
`timescale 1ns/1ps
`include "mem_cfg.svh"

module mem_subsys_tb;

    localparam int MAX_OPS = 64;                                 // room for the trace lines.

    logic               clk = 1'b0;
    logic               rst_i;
    mem_pkg::addr_t     fetch_addr_i;
    mem_pkg::word_t     fetch_data_o;
    logic               req_valid_i;
    mem_pkg::data_req_t req_i;
    logic               credit_o;
    logic               rsp_valid_o;
    mem_pkg::data_rsp_t rsp_o;
    logic               rsp_ready_i;
    logic               fetch_chk;                               // the current fetch is a trace test.
    mem_pkg::word_t     tr_exp;                                  // expected value from the trace.
    logic               tr_err;                                  // expected error flag from the trace.
    int                 tr_idx;                                  // trace line of the current operation.
    logic               done;                                    // stimulus and drain are finished.
    int                 err_cnt;
    int                 test_cnt;
    int                 rsp_cnt;
    logic               report_done;
    logic [31:0]        trace [0:7*MAX_OPS-1];                   // seven fields per trace line.
    int                 n_ops = 0;
    int                 n_data = 0;
    int                 held = 0;                                // credits the driver holds.

    always #5 clk = ~clk;

    mem_subsys uut (
        .clk (clk), .rst_i (rst_i), .fetch_addr_i (fetch_addr_i), .fetch_data_o (fetch_data_o),
        .req_valid_i (req_valid_i), .req_i (req_i), .credit_o (credit_o),
        .rsp_valid_o (rsp_valid_o), .rsp_o (rsp_o), .rsp_ready_i (rsp_ready_i)
    );

    mem_checker u_chk (
        .clk (clk), .rst_i (rst_i), .fetch_addr_i (fetch_addr_i), .fetch_data_o (fetch_data_o),
        .req_valid_i (req_valid_i), .req_i (req_i), .credit_o (credit_o),
        .rsp_valid_o (rsp_valid_o), .rsp_o (rsp_o), .rsp_ready_i (rsp_ready_i),
        .fetch_chk_i (fetch_chk), .tr_exp_i (tr_exp), .tr_err_i (tr_err), .tr_idx_i (tr_idx),
        .done_i (done), .err_cnt_o (err_cnt), .test_cnt_o (test_cnt), .rsp_cnt_o (rsp_cnt),
        .report_done_o (report_done)
    );

    // one clock edge, picking up a credit and clearing the one-cycle strobes.
    task automatic next_cycle();
        @(posedge clk);
        if (credit_o) held++;
        req_valid_i <= 1'b0;
        fetch_chk   <= 1'b0;
        rsp_ready_i <= ($urandom % 4) != 0;                      // ready about three cycles in four.
    endtask

    initial begin : driver
        int b;
        rst_i        <= 1'b1;
        fetch_addr_i <= '0;
        req_valid_i  <= 1'b0;
        req_i        <= '0;
        rsp_ready_i  <= 1'b0;
        fetch_chk    <= 1'b0;
        tr_exp       <= '0;
        tr_err       <= 1'b0;
        tr_idx       <= 0;
        done         <= 1'b0;
        void'($urandom(34433));
        $readmemh("test/mem_trace.txt", trace);
        while (n_ops < MAX_OPS && trace[7*n_ops] != 32'hf) n_ops++; // op f ends the trace.
        repeat (4) @(posedge clk);
        rst_i <= 1'b0;
        while (held < `MEM_CREDITS) next_cycle();                // the whole grant before any request.
        repeat (3) next_cycle();
        for (int i = 0; i < n_ops; i++) begin
            b = 7 * i;
            next_cycle();
            tr_exp <= trace[b+5];
            tr_err <= trace[b+6][0];
            tr_idx <= i;
            if (trace[b] == 32'h0) begin
                fetch_addr_i <= trace[b+3][15:0];
                fetch_chk    <= 1'b1;
            end else begin
                while (held == 0) next_cycle();                  // a request spends one credit.
                req_valid_i <= 1'b1;
                req_i.store <= (trace[b] == 32'h2);
                req_i.size  <= mem_pkg::size_e'(trace[b+1][1:0]);
                req_i.uns   <= trace[b+2][0];
                req_i.addr  <= trace[b+3][15:0];
                req_i.wdata <= trace[b+4];
                held--;
                n_data++;
            end
        end
        next_cycle();
        while (rsp_cnt < n_data) next_cycle();
        repeat (10) next_cycle();                                // let the last credits come back.
        done <= 1'b1;
        while (!report_done) next_cycle();
        if (err_cnt == 0 && test_cnt > 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // trace length times 20 cycles of 10 ns, plus 100 cycles of margin.
    initial begin : watchdog
        #1;
        #(n_ops * 200 + 1000);
        $display("Timeout: the run did not finish within %0d cycles", n_ops * 20 + 100);
        $display("Test failed");
        $finish;
    end

endmodule

// ==== test/mem_checker.sv ====
`timescale 1ns/1ps
`include "mem_cfg.svh"

module mem_checker (
    input  logic               clk,
    input  logic               rst_i,
    input  mem_pkg::addr_t     fetch_addr_i,
    input  mem_pkg::word_t     fetch_data_o,
    input  logic               req_valid_i,
    input  mem_pkg::data_req_t req_i,
    input  logic               credit_o,
    input  logic               rsp_valid_o,
    input  mem_pkg::data_rsp_t rsp_o,
    input  logic               rsp_ready_i,
    input  logic               fetch_chk_i,
    input  mem_pkg::word_t     tr_exp_i,
    input  logic               tr_err_i,
    input  int                 tr_idx_i,
    input  logic               done_i,
    output int                 err_cnt_o,
    output int                 test_cnt_o,
    output int                 rsp_cnt_o,
    output logic               report_done_o
);

    logic [7:0]     ref_mem [0:`MEM_DEPTH-1] = '{default: 8'h00}; // lane n of word a sits at a + n.
    logic [33:0]    exp_q [$];                                   // model response as {store, err, data}.
    logic [33:0]    tr_q [$];                                    // trace response as {store, err, data}.
    string          name_q [$];
    int             credits_seen;
    int             balance;                                     // credits the requester holds.
    int             outstanding;
    logic           started;
    logic           f1_v;                                        // a fetch waits for its data word.
    mem_pkg::word_t f1_exp;
    mem_pkg::word_t f1_tr;
    int             f1_idx;

    function automatic logic misaligned(mem_pkg::data_req_t r);
        return (r.size == mem_pkg::SZ_HALF && r.addr[0]) ||
               (r.size == mem_pkg::SZ_WORD && r.addr[1:0] != 2'b00);
    endfunction

    function automatic mem_pkg::word_t read_word(mem_pkg::addr_t a);
        mem_pkg::word_t w;
        for (int n = 0; n < 4; n++) w[8*n +: 8] = ref_mem[a + mem_pkg::addr_t'(n)];
        return w;
    endfunction

    function automatic mem_pkg::word_t load_value(mem_pkg::data_req_t r);
        mem_pkg::word_t w;
        logic [7:0]     b;
        logic [15:0]    h;
        w = read_word({r.addr[15:2], 2'b00});
        b = w[8*r.addr[1:0] +: 8];
        h = w[16*r.addr[1] +: 16];
        case (r.size)
            mem_pkg::SZ_BYTE: return r.uns ? {24'h0, b} : {{24{b[7]}}, b};
            mem_pkg::SZ_HALF: return r.uns ? {16'h0, h} : {{16{h[15]}}, h};
            default:          return w;
        endcase
    endfunction

    task automatic fail_plain(string what);
        err_cnt_o++;
        $display("Error: %s", what);
    endtask

    // compares against the model first, then against the trace column.
    task automatic check(string name, logic [33:0] mexp, logic [33:0] texp, logic [33:0] act);
        test_cnt_o++;
        if (act !== mexp || act !== texp) begin
            err_cnt_o++;
            $display("Fail %s expected 0x%09h actual 0x%09h", name,
                     (act !== mexp) ? mexp : texp, act);
        end else begin
            $display("Pass %s value 0x%09h", name, act);
        end
    endtask

    always @(negedge clk) begin
        logic           err;
        mem_pkg::word_t data;
        if (rst_i) begin
            err_cnt_o     = 0;
            test_cnt_o    = 0;
            rsp_cnt_o     = 0;
            report_done_o = 1'b0;
            credits_seen  = 0;
            balance       = 0;
            outstanding   = 0;
            started       = 1'b0;
            f1_v          = 1'b0;
        end else begin
            // the word for last cycle's fetch address is on fetch_data_o now.
            if (f1_v) check($sformatf("op%0d_fetch", f1_idx), {2'b00, f1_exp}, {2'b00, f1_tr},
                            {2'b00, fetch_data_o});
            f1_v   = fetch_chk_i;
            f1_exp = read_word(fetch_addr_i);                    // read before this cycle's store lands.
            f1_tr  = tr_exp_i;
            f1_idx = tr_idx_i;
            if (rsp_valid_o && !started) fail_plain("response valid before any request");
            if (rsp_valid_o && rsp_ready_i) begin
                rsp_cnt_o++;
                outstanding--;
                if (exp_q.size() == 0) fail_plain("response arrived with no request outstanding");
                else check(name_q.pop_front(), exp_q.pop_front(), tr_q.pop_front(),
                           {rsp_o.store, rsp_o.err, rsp_o.data});
            end
            if (req_valid_i) begin
                if (!started) begin
                    started = 1'b1;
                    check("reset_credits", 34'(`MEM_CREDITS), 34'(`MEM_CREDITS), 34'(credits_seen));
                end
                if (balance == 0) fail_plain("request issued without a credit");
                balance--;
                outstanding++;
                if (outstanding > `MEM_CREDITS) fail_plain("too many requests outstanding");
                err  = misaligned(req_i);
                data = (req_i.store || err) ? '0 : load_value(req_i);
                if (req_i.store && !err) begin
                    for (int n = 0; n < (1 << req_i.size); n++)
                        ref_mem[req_i.addr + mem_pkg::addr_t'(n)] = req_i.wdata[8*n +: 8];
                end
                exp_q.push_back({req_i.store, err, data});
                tr_q.push_back({req_i.store, tr_err_i, tr_exp_i});
                name_q.push_back($sformatf("op%0d_%s", tr_idx_i, req_i.store ? "store" : "load"));
            end
            if (credit_o) begin
                credits_seen++;
                balance++;
            end
            if (done_i && !report_done_o) begin
                if (credits_seen != `MEM_CREDITS + rsp_cnt_o)
                    fail_plain($sformatf("%0d credits came back for %0d response transfers",
                                         credits_seen - `MEM_CREDITS, rsp_cnt_o));
                if (exp_q.size() != 0)
                    fail_plain($sformatf("%0d responses never arrived", exp_q.size()));
                $display("Tests: %0d run, %0d errors", test_cnt_o, err_cnt_o);
                report_done_o = 1'b1;
            end
        end
    end

endmodule

// ==== design/mem_subsys.sv ====
`timescale 1ns/1ps

module mem_subsys (
    input  logic               clk,
    input  logic               rst_i,
    input  mem_pkg::addr_t     fetch_addr_i,
    output mem_pkg::word_t     fetch_data_o,
    input  logic               req_valid_i,
    input  mem_pkg::data_req_t req_i,
    output logic               credit_o,
    output logic               rsp_valid_o,
    output mem_pkg::data_rsp_t rsp_o,
    input  logic               rsp_ready_i
);

    logic               misalign;                                // refused access from the aligner.
    logic               ram_en;                                  // aligned access reaches the RAM.
    logic               push;                                    // response enters the queue.
    logic               pop;                                     // response left the queue.
    mem_pkg::acc_tag_t  tag;                                     // access info one cycle later.
    mem_pkg::be_t       be;                                      // write lanes.
    mem_pkg::word_t     wdata;                                   // lane-shifted store data.
    mem_pkg::word_t     rdata;                                   // registered RAM read word.
    mem_pkg::data_rsp_t rsp_new;                                 // response built from tag and read word.

    mem_ctrl u_ctrl (
        .clk         (clk),
        .rst_i       (rst_i),
        .req_valid_i (req_valid_i),
        .req_i       (req_i),
        .misalign_i  (misalign),
        .pop_i       (pop),
        .ram_en_o    (ram_en),
        .push_o      (push),
        .tag_o       (tag),
        .credit_o    (credit_o)
    );

    store_align u_align (
        .req_i      (req_i),
        .be_o       (be),
        .wdata_o    (wdata),
        .misalign_o (misalign)
    );

    ram_mem u_ram (
        .clk          (clk),
        .fetch_addr_i (fetch_addr_i),
        .fetch_data_o (fetch_data_o),
        .en_i         (ram_en),
        .be_i         (be),
        .addr_i       (req_i.addr),
        .wdata_i      (wdata),
        .rdata_o      (rdata)
    );

    load_extend u_ext (
        .tag_i   (tag),
        .rdata_i (rdata),
        .rsp_o   (rsp_new)
    );

    rsp_fifo u_fifo (
        .clk         (clk),
        .rst_i       (rst_i),
        .push_i      (push),
        .rsp_i       (rsp_new),
        .rsp_valid_o (rsp_valid_o),
        .rsp_o       (rsp_o),
        .rsp_ready_i (rsp_ready_i),
        .pop_o       (pop)
    );

endmodule

// ==== design/rsp_fifo.sv ====
`timescale 1ns/1ps
`include "mem_cfg.svh"

module rsp_fifo (
    input  logic                clk,
    input  logic                rst_i,
    input  logic                push_i,
    input  mem_pkg::data_rsp_t  rsp_i,
    output logic                rsp_valid_o,
    output mem_pkg::data_rsp_t  rsp_o,
    input  logic                rsp_ready_i,
    output logic                pop_o
);

    localparam int PTR_W = $clog2(`MEM_CREDITS);                 // index width into the ring.

    mem_pkg::data_rsp_t   slots [0:`MEM_CREDITS-1];              // ring storage.
    logic [PTR_W-1:0]     wr_ptr;                                // next slot to fill.
    logic [PTR_W-1:0]     rd_ptr;                                // oldest filled slot.
    mem_pkg::credit_cnt_t cnt;                                   // filled slots in the ring.
    logic                 load;                                  // move the oldest slot to the head.

    assign pop_o = rsp_valid_o & rsp_ready_i;                    // one transfer per cycle at most.
    assign load  = (cnt != '0) && (!rsp_valid_o || pop_o);       // refill an empty or leaving head.

    always_ff @(posedge clk) begin
        if (rst_i) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            cnt         <= '0;
            rsp_valid_o <= 1'b0;
        end else begin
            cnt <= cnt + mem_pkg::credit_cnt_t'(push_i) - mem_pkg::credit_cnt_t'(load);
            if (push_i) begin
                wr_ptr <= (wr_ptr == PTR_W'(`MEM_CREDITS - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (load) begin
                rd_ptr      <= (rd_ptr == PTR_W'(`MEM_CREDITS - 1)) ? '0 : rd_ptr + 1'b1;
                rsp_valid_o <= 1'b1;
            end else if (pop_o) begin
                rsp_valid_o <= 1'b0;                             // head drained and nothing behind it.
            end
        end
    end

    // payload moves through the ring and into the head register.
    always_ff @(posedge clk) begin
        if (push_i) begin
            slots[wr_ptr] <= rsp_i;
        end
        if (load) begin
            rsp_o <= slots[rd_ptr];
        end
    end

    // the credit count sizes the ring so a push always finds room.
    a_no_overflow: assert property (@(posedge clk) disable iff (rst_i)
        !(push_i && (cnt == `MEM_CREDITS)));

endmodule

// ==== design/load_extend.sv ====
`timescale 1ns/1ps

module load_extend (
    input  mem_pkg::acc_tag_t tag_i,
    input  mem_pkg::word_t    rdata_i,
    output mem_pkg::data_rsp_t rsp_o
);

    logic [7:0]     lane_b;                                      // addressed byte.
    logic [15:0]    lane_h;                                      // addressed half.
    logic           sgn_b;                                       // fill bit for a byte load.
    logic           sgn_h;                                       // fill bit for a half load.
    mem_pkg::word_t ext;                                         // extended load value.

    always_comb begin
        lane_b = rdata_i[8*tag_i.offs +: 8];                     // shift the byte down to bit 0.
        lane_h = rdata_i[16*tag_i.offs[1] +: 16];                // the half sits in lane 0 or 2.
        sgn_b  = lane_b[7] & ~tag_i.uns;
        sgn_h  = lane_h[15] & ~tag_i.uns;
        case (tag_i.size)
            mem_pkg::SZ_BYTE: ext = {{24{sgn_b}}, lane_b};
            mem_pkg::SZ_HALF: ext = {{16{sgn_h}}, lane_h};
            default:          ext = rdata_i;
        endcase
    end

    // stores and refused accesses return no data.
    assign rsp_o.data  = (tag_i.store || tag_i.err) ? '0 : ext;
    assign rsp_o.err   = tag_i.err;
    assign rsp_o.store = tag_i.store;

endmodule

// ==== design/ram_mem.sv ====
`timescale 1ns/1ps
`include "mem_cfg.svh"

module ram_mem (
    input  logic           clk,
    input  mem_pkg::addr_t fetch_addr_i,
    output mem_pkg::word_t fetch_data_o,
    input  logic           en_i,
    input  mem_pkg::be_t   be_i,
    input  mem_pkg::addr_t addr_i,
    input  mem_pkg::word_t wdata_i,
    output mem_pkg::word_t rdata_o
);

    localparam int LANES = `MEM_DATA_W / 8;                      // bytes per word.

    // byte lane n of the word at address a lives at a + n.
    logic [7:0] mem [0:`MEM_DEPTH-1] = '{default: 8'h00};

    mem_pkg::addr_t base_a;                                      // data address with the offset cleared.

    assign base_a = {addr_i[`MEM_ADDR_W-1:2], 2'b00};

    // data port writes the enabled lanes or reads the whole aligned word.
    always_ff @(posedge clk) begin
        if (en_i) begin
            if (be_i != '0) begin
                for (int n = 0; n < LANES; n++) begin
                    if (be_i[n]) begin
                        mem[base_a | mem_pkg::addr_t'(n)] <= wdata_i[8*n +: 8];
                    end
                end
            end else begin
                for (int n = 0; n < LANES; n++) begin
                    rdata_o[8*n +: 8] <= mem[base_a | mem_pkg::addr_t'(n)];
                end
            end
        end
    end

    // fetch port reads every cycle with no handshake.
    // A same-cycle store to the same byte is not visible here yet.
    always_ff @(posedge clk) begin
        for (int n = 0; n < LANES; n++) begin
            fetch_data_o[8*n +: 8] <= mem[fetch_addr_i + mem_pkg::addr_t'(n)];
        end
    end

endmodule

// ==== design/store_align.sv ====
`timescale 1ns/1ps

module store_align (
    input  mem_pkg::data_req_t req_i,
    output mem_pkg::be_t       be_o,
    output mem_pkg::word_t     wdata_o,
    output logic               misalign_o
);

    mem_pkg::be_t lane_be;                                       // enables before the store gate.

    always_comb begin
        misalign_o = 1'b0;
        lane_be    = 4'b1111;
        wdata_o    = req_i.wdata;
        case (req_i.size)
            mem_pkg::SZ_BYTE: begin
                lane_be = 4'b0001 << req_i.addr[1:0];            // any offset is fine for a byte.
                wdata_o = {4{req_i.wdata[7:0]}};                 // copy the byte onto every lane.
            end
            mem_pkg::SZ_HALF: begin
                misalign_o = req_i.addr[0];                      // a half must start on an even byte.
                lane_be    = 4'b0011 << req_i.addr[1:0];
                wdata_o    = {2{req_i.wdata[15:0]}};             // both halves carry the data.
            end
            default: begin
                misalign_o = (req_i.addr[1:0] != 2'b00);         // words need 4-byte alignment.
            end
        endcase
    end

    // loads and refused stores write nothing.
    assign be_o = (req_i.store && !misalign_o) ? lane_be : '0;

endmodule

// ==== design/mem_ctrl.sv ====
`timescale 1ns/1ps
`include "mem_cfg.svh"

module mem_ctrl (
    input  logic               clk,
    input  logic               rst_i,
    input  logic               req_valid_i,
    input  mem_pkg::data_req_t req_i,
    input  logic               misalign_i,
    input  logic               pop_i,
    output logic               ram_en_o,
    output logic               push_o,
    output mem_pkg::acc_tag_t  tag_o,
    output logic               credit_o
);

    mem_pkg::ctrl_state_e state;                                 // grant or run phase.
    mem_pkg::credit_cnt_t grant_cnt;                             // initial credits handed out.
    mem_pkg::credit_cnt_t owed;                                  // pops whose credit is pending.
    mem_pkg::credit_cnt_t inflight;                              // accepted but not yet popped.
    mem_pkg::credit_cnt_t req_bal;                               // credits the requester holds.
    logic                 give;                                  // return one credit this cycle.

    // a misaligned access never touches the RAM.
    assign ram_en_o = req_valid_i & ~misalign_i;

    // in run phase a credit goes back for a pop now or one owed from before.
    assign give = (state == mem_pkg::ST_RUN) && (pop_i || (owed != '0));

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state     <= mem_pkg::ST_GRANT;
            grant_cnt <= '0;
            owed      <= '0;
            credit_o  <= 1'b0;                                   // no credit during or just after reset.
        end else begin
            case (state)
                mem_pkg::ST_GRANT: begin
                    credit_o  <= 1'b1;                           // one initial credit per cycle.
                    grant_cnt <= grant_cnt + 1'b1;
                    owed      <= owed + mem_pkg::credit_cnt_t'(pop_i); // early pops wait for run.
                    if (grant_cnt == mem_pkg::credit_cnt_t'(`MEM_CREDITS - 1)) begin
                        state <= mem_pkg::ST_RUN;
                    end
                end
                default: begin
                    credit_o <= give;
                    owed     <= owed + mem_pkg::credit_cnt_t'(pop_i)
                                     - mem_pkg::credit_cnt_t'(give);
                end
            endcase
        end
    end

    // count of accesses between acceptance and the response transfer.
    always_ff @(posedge clk) begin
        if (rst_i) begin
            inflight <= '0;
            req_bal  <= '0;
            push_o   <= 1'b0;
        end else begin
            inflight <= inflight + mem_pkg::credit_cnt_t'(req_valid_i)
                                 - mem_pkg::credit_cnt_t'(pop_i);
            req_bal  <= req_bal + mem_pkg::credit_cnt_t'(credit_o)
                                - mem_pkg::credit_cnt_t'(req_valid_i);
            push_o   <= req_valid_i;                             // response is ready one cycle later.
        end
    end

    // the tag lines up with the registered RAM read word.
    always_ff @(posedge clk) begin
        tag_o.size  <= req_i.size;
        tag_o.uns   <= req_i.uns;
        tag_o.store <= req_i.store;
        tag_o.err   <= misalign_i;
        tag_o.offs  <= req_i.addr[1:0];
    end

    // the credit loop keeps the number of open accesses bounded.
    a_inflight_bound: assert property (@(posedge clk) disable iff (rst_i)
        inflight <= `MEM_CREDITS);

    // a request is only legal while the requester holds a credit from an earlier cycle.
    a_req_has_credit: assert property (@(posedge clk) disable iff (rst_i)
        req_valid_i |-> (req_bal != '0));

endmodule

// ==== common/mem_pkg.sv ====
`include "mem_cfg.svh"

package mem_pkg;

    typedef logic [`MEM_ADDR_W-1:0] addr_t;                  // byte address into the RAM.
    typedef logic [`MEM_DATA_W-1:0] word_t;                  // one data word.
    typedef logic [`MEM_DATA_W/8-1:0] be_t;                  // one enable bit per byte lane.
    typedef logic [$clog2(`MEM_CREDITS+2)-1:0] credit_cnt_t; // holds the credit count plus one.

    typedef enum logic [1:0] {
        SZ_BYTE = 2'b00,                                     // one byte.
        SZ_HALF = 2'b01,                                     // two bytes on an even address.
        SZ_WORD = 2'b10                                      // four bytes on a 4-aligned address.
    } size_e;

    typedef enum logic {
        ST_GRANT = 1'b0,                                     // initial credits are handed out.
        ST_RUN   = 1'b1                                      // credits come back with responses.
    } ctrl_state_e;

    // a data-port request as the requester presents it.
    typedef struct packed {
        logic  store;                                        // high for a store.
        size_e size;                                         // access size.
        logic  uns;                                          // zero-extend a load when high.
        addr_t addr;                                         // byte address.
        word_t wdata;                                        // store data in the low lanes.
    } data_req_t;

    typedef struct packed {
        word_t data;                                         // extended load data.
        logic  err;                                          // the access was misaligned.
        logic  store;                                        // the response belongs to a store.
    } data_rsp_t;

    // what the response path needs to know about an access in flight.
    typedef struct packed {
        size_e      size;                                    // access size.
        logic       uns;                                     // zero-extend the load.
        logic       store;                                   // store flag.
        logic       err;                                     // misalignment seen at acceptance.
        logic [1:0] offs;                                    // low address bits.
    } acc_tag_t;

endpackage

// ==== common/mem_cfg.svh ====
`ifndef MEM_CFG_SVH
`define MEM_CFG_SVH

// sizing of the memory subsystem that serves the core in simulation.

// byte address width, which covers the whole 64 KiB array.
`define MEM_ADDR_W 16

// width of one data word on both ports.
`define MEM_DATA_W 32

// number of bytes held in the RAM.
`define MEM_DEPTH 65536

// credits granted to the data-port requester after reset.
// This also bounds the accesses in flight and the response queue depth.
`define MEM_CREDITS 4

`endif
